// File: frontend.f
verilog/fetch_types.sv
verilog/inst_mem.sv
verilog/fetch_unit.sv
verilog/inst_queue.sv
verilog/decode_unit.sv
verilog/frontend_top.sv
verification/frontend_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= frontend_tb
FILELIST  ?= frontend.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= All tests passed!

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$($(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: verification/frontend_tb.sv
`timescale 1ns/1ps

module frontend_tb;

    import fetch_types::*;

    localparam int          queue_depth   = 16;
    localparam int          mem_words     = 256;
    localparam logic [31:0] reset_pc      = 32'h0;
    localparam int          addr_w        = $clog2(mem_words);
    localparam int          count_w       = $clog2(queue_depth) + 1;
    localparam logic [count_w-1:0] full_count = count_w'(queue_depth);
    localparam int          wait_limit    = 200;
    localparam int          crafted_base  = 128;   // Word index of the hand-made block.
    localparam logic [31:0] redirect_addr = 32'h0000_0100;
    localparam logic [31:0] crafted_imm [7] = '{32'hffff_ffff, 32'h0000_0123, 32'hffff_f800,
        32'h0000_07ff, 32'hffff_ff9c, 32'h0000_0064, 32'h0000_0000};
    localparam logic [31:0] crafted_rs2 [7] = '{0, 0, 0, 0, 0, 0, 7};

    logic                 clk = 1'b0;
    logic                 rst;
    prog_write_t          prog;
    redirect_t            redirect;
    logic                 dec_valid;
    logic                 dec_ready;
    decoded_inst_t        dec_inst;
    logic [count_w-1:0]   queue_count;

    inst_t       program_words [mem_words];
    integer      seed = 36929;
    int          error_count = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    bit          timed_out = 1'b0;
    logic [31:0] next_pc;   // Pc of the next instruction the backend should see.

    frontend_top #(
        .queue_depth (queue_depth),
        .mem_words   (mem_words),
        .reset_pc    (reset_pc)
    ) dut_i (
        .clk         (clk),
        .rst         (rst),
        .prog        (prog),
        .redirect    (redirect),
        .dec_valid   (dec_valid),
        .dec_ready   (dec_ready),
        .dec_inst    (dec_inst),
        .queue_count (queue_count)
    );

    initial begin
        forever #10 clk = ~clk;
    end

    // ####################
    // Program and model
    // ####################

    function automatic inst_t make_itype(input logic [11:0] imm12, input logic [4:0] rs1,
                                         input logic [2:0] funct3, input logic [4:0] rd,
                                         input logic [6:0] opcode);
        return {imm12, rs1, funct3, rd, opcode};
    endfunction

    task automatic build_program();
        logic [31:0] r;
        logic [6:0]  opcode;
        for (int i = 0; i < mem_words; i++) begin
            r = $random(seed);
            case (r[1:0])
                2'd0:    opcode = op_imm;
                2'd1:    opcode = op_load;
                2'd2:    opcode = op_jalr;
                default: opcode = 7'b0110011;   // R-format ALU op.
            endcase
            program_words[i] = {r[31:7], opcode};
        end
        program_words[crafted_base + 0] = make_itype(12'hfff, 5'd5, 3'd0, 5'd1, op_imm);
        program_words[crafted_base + 1] = make_itype(12'h123, 5'd6, 3'd4, 5'd2, op_imm);
        program_words[crafted_base + 2] = make_itype(12'h800, 5'd7, 3'd2, 5'd3, op_load);
        program_words[crafted_base + 3] = make_itype(12'h7ff, 5'd8, 3'd0, 5'd4, op_load);
        program_words[crafted_base + 4] = make_itype(12'hf9c, 5'd9, 3'd0, 5'd5, op_jalr);
        program_words[crafted_base + 5] = make_itype(12'h064, 5'd10, 3'd0, 5'd6, op_jalr);
        program_words[crafted_base + 6] = {7'b0100000, 5'd7, 5'd3, 3'd0, 5'd9, 7'b0110011};
    endtask

    function automatic decoded_inst_t reference_decode(input logic [31:0] pc);
        inst_t         word;
        decoded_inst_t d;
        word       = program_words[pc[addr_w+1:2]];
        d.pc       = pc;
        d.opcode   = word[6:0];
        d.rd       = word[11:7];
        d.funct3   = word[14:12];
        d.rs1      = word[19:15];
        d.is_itype = (word[6:0] == op_imm) || (word[6:0] == op_load) || (word[6:0] == op_jalr);
        d.rs2      = d.is_itype ? 5'd0 : word[24:20];
        d.imm      = d.is_itype ? {{20{word[31]}}, word[31:20]} : 32'd0;
        return d;
    endfunction

    task automatic apply_reset();
        rst = 1'b1;
        repeat (10) @(negedge clk);
        rst = 1'b0;
    endtask

    // Starts inside reset and stays ahead of fetch, which reads at most one word a cycle.
    task automatic load_program();
        for (int i = 0; i < mem_words; i++) begin
            @(negedge clk);
            prog.we   = 1'b1;
            prog.addr = 16'(i);
            prog.data = program_words[i];
        end
        @(negedge clk);
        prog.we = 1'b0;
    endtask

    // ####################
    // Checks and handshakes
    // ####################

    task automatic check_inst(input string test, input decoded_inst_t expected,
                              input decoded_inst_t actual);
        assert (actual === expected) else begin
            $display("FAILED %s: expected %h actual %h", test, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_value(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("FAILED %s: %s expected %h actual %h", test, what, expected, actual);
            error_count++;
        end
    endtask

    task automatic report_timeout(input string test, input string what);
        $display("%s: gave up waiting for %s", test, what);
        timed_out = 1'b1;
    endtask

    task automatic wait_output(input string test);
        int waited;
        waited = 0;
        while (!dec_valid && waited < wait_limit) begin
            @(negedge clk);
            waited++;
        end
        if (!dec_valid) report_timeout(test, "a decoded instruction");
    endtask

    // Accepts one instruction and compares it with the model at next_pc.
    task automatic consume(input string test);
        dec_ready = 1'b1;
        wait_output(test);
        if (!timed_out) begin
            check_inst(test, reference_decode(next_pc), dec_inst);
            next_pc = next_pc + 32'd4;
            @(negedge clk);
        end
    endtask

    task automatic send_redirect(input logic [31:0] target);
        redirect.valid = 1'b1;
        redirect.pc    = target;
        @(negedge clk);
        redirect.valid = 1'b0;
        next_pc        = target;
    endtask

    task automatic fill_queue(input string test);
        int waited;
        waited = 0;
        dec_ready = 1'b0;
        while (queue_count != full_count && waited < wait_limit) begin
            @(negedge clk);
            waited++;
        end
        if (queue_count != full_count) report_timeout(test, "a full queue");
    endtask

    task automatic finish_test(input string test, input int errors_before);
        int errors;
        errors = error_count - errors_before;
        tests_run++;
        if (errors != 0 || timed_out) begin
            tests_failed++;
            $display("%s: failed with %0d wrong values", test, errors);
        end else begin
            $display("%s: ok", test);
        end
    endtask

    // ####################
    // Directed tests
    // ####################

    task automatic in_order_stream();
        int errors_before;
        errors_before = error_count;
        next_pc = reset_pc;
        for (int i = 0; i < 40 && !timed_out; i++) consume("in_order_stream");
        finish_test("in_order_stream", errors_before);
    endtask

    task automatic itype_immediates();
        int    errors_before;
        string name;
        errors_before = error_count;
        name = "itype_immediates";
        dec_ready = 1'b1;
        send_redirect(32'(crafted_base * 4));
        for (int k = 0; k < 7 && !timed_out; k++) begin
            wait_output(name);
            if (!timed_out) begin
                check_value(name, "pc", next_pc, dec_inst.pc);
                check_value(name, "imm", crafted_imm[k], dec_inst.imm);
                check_value(name, "rs2", crafted_rs2[k], 32'(dec_inst.rs2));
                check_value(name, "is_itype", (k < 6) ? 32'd1 : 32'd0, 32'(dec_inst.is_itype));
                next_pc = next_pc + 32'd4;
                @(negedge clk);
            end
        end
        finish_test(name, errors_before);
    endtask

    task automatic backpressure_fill();
        int            errors_before;
        decoded_inst_t held;
        errors_before = error_count;
        fill_queue("backpressure_fill");
        held = dec_inst;
        for (int i = 0; i < 20 && !timed_out; i++) begin
            check_value("backpressure_fill", "queue_count", 32'(full_count), 32'(queue_count));
            check_value("backpressure_fill", "dec_valid", 32'd1, 32'(dec_valid));
            check_inst("backpressure_fill", held, dec_inst);
            @(negedge clk);
        end
        for (int i = 0; i < 24 && !timed_out; i++) consume("backpressure_fill");
        finish_test("backpressure_fill", errors_before);
    endtask

    task automatic occupancy_drain();
        int errors_before;
        errors_before = error_count;
        fill_queue("occupancy_drain");
        for (int i = 0; i < 24 && !timed_out; i++) begin
            consume("occupancy_drain");
            dec_ready = 1'b0;
            repeat (3) begin
                assert (queue_count <= full_count) else begin
                    $display("FAILED occupancy_drain: queue_count expected at most %0d actual %0d",
                             full_count, queue_count);
                    error_count++;
                end
                @(negedge clk);
            end
        end
        finish_test("occupancy_drain", errors_before);
    endtask

    task automatic redirect_flush();
        int errors_before;
        errors_before = error_count;
        dec_ready = 1'b1;
        send_redirect(redirect_addr);
        check_value("redirect_flush", "dec_valid", 32'd0, 32'(dec_valid));   // Flushed on the edge.
        for (int i = 0; i < 24 && !timed_out; i++) consume("redirect_flush");
        finish_test("redirect_flush", errors_before);
    endtask

    initial begin
        rst       = 1'b1;
        prog      = '0;
        redirect  = '0;
        dec_ready = 1'b0;
        next_pc   = reset_pc;
        build_program();
        fork
            apply_reset();
            load_program();
        join
        in_order_stream();
        if (!timed_out) itype_immediates();
        if (!timed_out) backpressure_fill();
        if (!timed_out) occupancy_drain();
        if (!timed_out) redirect_flush();
        $display("Tests run %0d, tests failed %0d, wrong values %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0 && tests_failed == 0 && !timed_out) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: verilog/frontend_top.sv
`timescale 1ns/1ps

module frontend_top #(
    parameter int                           queue_depth = 16,
    parameter int                           mem_words   = 256,
    parameter logic [fetch_types::xlen-1:0] reset_pc    = '0
) (
    input  logic                           clk,
    input  logic                           rst,
    input  fetch_types::prog_write_t       prog,
    input  fetch_types::redirect_t         redirect,
    output logic                           dec_valid,
    input  logic                           dec_ready,
    output fetch_types::decoded_inst_t     dec_inst,
    output logic [$clog2(queue_depth):0]   queue_count
);

    import fetch_types::*;

    logic [$clog2(mem_words)-1:0] rd_addr;
    inst_t                        rd_data;

    logic          fetch_valid;
    logic          fetch_ready;
    fetch_packet_t fetch_packet;

    logic          queue_valid;
    logic          queue_ready;
    fetch_packet_t queue_packet;

    inst_mem #(
        .mem_words (mem_words)
    ) mem_i (
        .clk     (clk),
        .prog    (prog),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    fetch_unit #(
        .mem_words (mem_words),
        .reset_pc  (reset_pc)
    ) fetch_i (
        .clk          (clk),
        .rst          (rst),
        .redirect     (redirect),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .fetch_valid  (fetch_valid),
        .fetch_packet (fetch_packet),
        .fetch_ready  (fetch_ready)
    );

    inst_queue #(
        .depth (queue_depth)
    ) queue_i (
        .clk        (clk),
        .rst        (rst),
        .flush      (redirect.valid),   // A redirect empties the queue.
        .in_valid   (fetch_valid),
        .in_ready   (fetch_ready),
        .in_packet  (fetch_packet),
        .out_valid  (queue_valid),
        .out_ready  (queue_ready),
        .out_packet (queue_packet),
        .count      (queue_count)
    );

    decode_unit decode_i (
        .clk       (clk),
        .rst       (rst),
        .flush     (redirect.valid),
        .in_valid  (queue_valid),
        .in_ready  (queue_ready),
        .in_packet (queue_packet),
        .dec_valid (dec_valid),
        .dec_ready (dec_ready),
        .dec_inst  (dec_inst)
    );

endmodule

// File: verilog/decode_unit.sv
`timescale 1ns/1ps

module decode_unit (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          flush,
    input  logic                          in_valid,
    output logic                          in_ready,
    input  fetch_types::fetch_packet_t    in_packet,
    output logic                          dec_valid,
    input  logic                          dec_ready,
    output fetch_types::decoded_inst_t    dec_inst
);

    import fetch_types::*;

    inst_u         instr;
    decoded_inst_t dec_next;
    logic          is_itype;
    logic          take;

    assign instr = in_packet.instr;

    assign is_itype = instr.r_view.opcode inside {op_imm, op_load, op_jalr};

    // ####################
    // Field extraction
    // ####################

    always_comb begin
        dec_next.pc       = in_packet.pc;
        dec_next.opcode   = instr.r_view.opcode;
        dec_next.rd       = instr.r_view.rd;
        dec_next.rs1      = instr.r_view.rs1;
        dec_next.funct3   = instr.r_view.funct3;
        dec_next.is_itype = is_itype;
        if (is_itype) begin
            dec_next.rs2 = '0;   // The rs2 bits hold part of the immediate here.
            dec_next.imm = {{(xlen-12){instr.i_view.imm12[11]}}, instr.i_view.imm12};
        end else begin
            dec_next.rs2 = instr.r_view.rs2;
            dec_next.imm = '0;
        end
    end

    // ####################
    // Output register
    // ####################

    assign in_ready = ~dec_valid | dec_ready;   // Empty or being drained this cycle.
    assign take     = in_ready & in_valid;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            dec_valid <= 1'b0;
        end else if (in_ready) begin
            dec_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            dec_inst <= dec_next;
        end
    end

endmodule

// File: verilog/inst_queue.sv
`timescale 1ns/1ps

module inst_queue #(
    parameter int depth = 16
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         flush,
    input  logic                         in_valid,
    output logic                         in_ready,
    input  fetch_types::fetch_packet_t   in_packet,
    output logic                         out_valid,
    input  logic                         out_ready,
    output fetch_types::fetch_packet_t   out_packet,
    output logic [$clog2(depth):0]       count
);

    import fetch_types::*;

    localparam int idx_w = $clog2(depth);

    fetch_packet_t entries [depth];

    logic [idx_w:0]   wr_ptr;
    logic [idx_w:0]   rd_ptr;
    logic [idx_w-1:0] wr_idx;
    logic [idx_w-1:0] rd_idx;
    logic             wr_flag;
    logic             rd_flag;
    logic             full;
    logic             empty;
    logic             enq;
    logic             deq;
    logic [idx_w:0]   count_next;

    assign {wr_flag, wr_idx} = wr_ptr;
    assign {rd_flag, rd_idx} = rd_ptr;

    // Same index with opposite wrap flags means the writer is a full lap ahead.
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_idx == rd_idx) && (wr_flag != rd_flag);

    assign in_ready   = ~full;
    assign out_valid  = ~empty;
    assign out_packet = entries[rd_idx];

    assign enq = in_valid & ~full;
    assign deq = out_ready & ~empty;

    // ####################
    // Pointers and storage
    // ####################

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (enq) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (deq) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (enq) begin
            entries[wr_idx] <= in_packet;
        end
    end

    // ####################
    // Occupancy counter
    // ####################

    always_comb begin
        count_next = count;
        if (enq) begin
            count_next = count_next + 1'b1;
        end
        if (deq) begin
            count_next = count_next - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            count <= '0;
        end else begin
            count <= count_next;
        end
    end

endmodule

// File: verilog/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit #(
    parameter int                           mem_words = 256,
    parameter logic [fetch_types::xlen-1:0] reset_pc  = '0
) (
    input  logic                          clk,
    input  logic                          rst,
    input  fetch_types::redirect_t        redirect,
    output logic [$clog2(mem_words)-1:0]  rd_addr,
    input  fetch_types::inst_t            rd_data,
    output logic                          fetch_valid,
    output fetch_types::fetch_packet_t    fetch_packet,
    input  logic                          fetch_ready
);

    import fetch_types::*;

    localparam int addr_w = $clog2(mem_words);

    logic [xlen-1:0] pc;          // Next address to request.
    logic [xlen-1:0] req_pc;      // Address of the read in flight.
    logic            inflight;
    logic            slot_free;
    logic            issue;
    logic            capture;

    assign slot_free = ~fetch_valid | fetch_ready;   // Packet slot is empty after this edge.
    assign issue     = slot_free & ~redirect.valid;
    assign capture   = inflight & slot_free & ~redirect.valid;

    // When stalled the pending address is read again, so rd_data keeps its word.
    assign rd_addr = issue ? pc[addr_w+1:2] : req_pc[addr_w+1:2];

    // ####################
    // Control state
    // ####################

    always_ff @(posedge clk) begin
        if (rst) begin
            pc          <= reset_pc;
            inflight    <= 1'b0;
            fetch_valid <= 1'b0;
        end else if (redirect.valid) begin
            pc          <= redirect.pc;   // Everything in flight is dropped.
            inflight    <= 1'b0;
            fetch_valid <= 1'b0;
        end else begin
            if (issue) begin
                pc       <= pc + xlen'(4);
                inflight <= 1'b1;
            end
            if (slot_free) begin
                fetch_valid <= inflight;   // The returning word fills the slot.
            end
        end
    end

    // ####################
    // Payload registers
    // ####################

    always_ff @(posedge clk) begin
        if (issue) begin
            req_pc <= pc;
        end
        if (capture) begin
            fetch_packet.pc    <= req_pc;
            fetch_packet.instr <= rd_data;
        end
    end

endmodule

// File: verilog/inst_mem.sv
`timescale 1ns/1ps

module inst_mem #(
    parameter int mem_words = 256
) (
    input  logic                          clk,
    input  fetch_types::prog_write_t      prog,
    input  logic [$clog2(mem_words)-1:0]  rd_addr,
    output fetch_types::inst_t            rd_data
);

    import fetch_types::*;

    localparam int addr_w = $clog2(mem_words);

    inst_t mem [mem_words];

    logic [addr_w-1:0] wr_addr;

    assign wr_addr = prog.addr[addr_w-1:0];   // Upper index bits beyond the array are ignored.

    // ####################
    // Program load port
    // ####################

    always_ff @(posedge clk) begin
        if (prog.we) begin
            mem[wr_addr] <= prog.data;
        end
    end

    // ####################
    // Registered read
    // ####################

    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];   // A read in the same cycle as a write returns the old word.
    end

endmodule

// File: verilog/fetch_types.sv
package fetch_types;

    localparam int unsigned xlen = 32;

    typedef logic [xlen-1:0] inst_t;

    // ####################
    // Instruction formats
    // ####################

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;   // Signed immediate of the I-format.
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r_view;
        i_fmt_t i_view;
    } inst_u;

    localparam logic [6:0] op_imm  = 7'b0010011;
    localparam logic [6:0] op_load = 7'b0000011;
    localparam logic [6:0] op_jalr = 7'b1100111;

    // ####################
    // Stage payloads
    // ####################

    typedef struct packed {
        logic [xlen-1:0] pc;
        inst_u           instr;
    } fetch_packet_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [6:0]      opcode;
        logic [4:0]      rd;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [2:0]      funct3;
        logic [xlen-1:0] imm;
        logic            is_itype;
    } decoded_inst_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
    } redirect_t;

    typedef struct packed {
        logic        we;
        logic [15:0] addr;   // Word index, not a byte address.
        inst_t       data;
    } prog_write_t;

endpackage
